/* common/core_cfg_pkg.sv */
package core_cfg_pkg;

    // Architectural register file
    localparam int ARN_BITS = 5;
    localparam int ARCH_REGS = 1 << ARN_BITS;

    // Program counter width
    localparam int PC_BITS = 64;

    // Defaults for the back end, overridden from the top level
    localparam int DEFAULT_PRN_BITS = 6;
    localparam int DEFAULT_ID_BITS = 4;
    localparam int DEFAULT_FU_COUNT = 4;

endpackage

/* common/rob_types_pkg.sv */
package rob_types_pkg;

    // Widest ROB index that a flush link can carry
    localparam int LINK_BITS = 8;

    typedef enum logic [1:0] {
        ISSUED   = 2'd0,
        COMPLETE = 2'd1,
        FLUSHED  = 2'd2
    } rob_state_t;

    // Youngest entry of a flush block holds the target id of that block
    typedef struct packed {
        logic [core_cfg_pkg::PC_BITS-LINK_BITS-1:0] zero;
        logic [LINK_BITS-1:0]                       target_id;
    } flush_link_t;

    // Same payload word, read as a PC while live and as a link once flushed
    typedef union packed {
        logic [core_cfg_pkg::PC_BITS-1:0] pc;
        flush_link_t                      link;
    } rob_payload_u;

endpackage

/* rename/rename_map.sv */
module rename_map #(
    parameter int PRN_BITS = 6
) (
    input  logic                             clk,
    input  logic                             rst,

    // Lookup for the instruction being dispatched
    input  logic [core_cfg_pkg::ARN_BITS-1:0] read_arn,
    output logic [PRN_BITS-1:0]               read_prn,

    // New mapping from dispatch
    input  logic                             write_en,
    input  logic [core_cfg_pkg::ARN_BITS-1:0] write_arn,
    input  logic [PRN_BITS-1:0]               write_prn,

    // Undo of a mapping during a flush walk
    input  logic                             restore_en,
    input  logic [core_cfg_pkg::ARN_BITS-1:0] restore_arn,
    input  logic [PRN_BITS-1:0]               restore_prn
);

    localparam int MAP_SIZE = 1 << core_cfg_pkg::ARN_BITS;

    logic [PRN_BITS-1:0] map [MAP_SIZE];

    assign read_prn = map[read_arn];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity mapping, arn i lives in prn i
            for (int i = 0; i < MAP_SIZE; i++) begin
                map[i] <= PRN_BITS'(i);
            end
        end else begin
            // r0 keeps its mapping forever
            if (write_en && write_arn != '0) begin
                map[write_arn] <= write_prn;
            end
            if (restore_en && restore_arn != '0) begin
                map[restore_arn] <= restore_prn;
            end
        end
    end

endmodule

/* rename/free_list.sv */
module free_list #(
    parameter int PRN_BITS  = 6,
    parameter int ARCH_REGS = 32
) (
    input  logic                clk,
    input  logic                rst,

    // Pop side, the head prn is visible before the pop
    input  logic                alloc_req,
    output logic [PRN_BITS-1:0] alloc_prn,
    output logic                empty,

    // Push side for retired or flushed prns
    input  logic                free_push,
    input  logic [PRN_BITS-1:0] free_prn
);

    localparam int DEPTH    = (1 << PRN_BITS) - ARCH_REGS;
    localparam int PTR_BITS = $clog2(DEPTH);

    logic [PRN_BITS-1:0] slots [DEPTH];

    logic [PTR_BITS-1:0] rd_idx;
    logic [PTR_BITS-1:0] wr_idx;
    logic                rd_wrap;
    logic                wr_wrap;

    // Same index with equal wrap bits means nothing is stored
    assign empty     = (rd_idx == wr_idx) && (rd_wrap == wr_wrap);
    assign alloc_prn = slots[rd_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Start full with every prn above the architectural ones
            for (int i = 0; i < DEPTH; i++) begin
                slots[i] <= PRN_BITS'(ARCH_REGS + i);
            end
            rd_idx  <= '0;
            wr_idx  <= '0;
            rd_wrap <= 1'b0;
            wr_wrap <= 1'b1;
        end else begin
            if (alloc_req) begin
                if (rd_idx == PTR_BITS'(DEPTH - 1)) begin
                    rd_idx  <= '0;
                    rd_wrap <= ~rd_wrap;
                end else begin
                    rd_idx <= rd_idx + 1'b1;
                end
            end
            if (free_push) begin
                slots[wr_idx] <= free_prn;
                if (wr_idx == PTR_BITS'(DEPTH - 1)) begin
                    wr_idx  <= '0;
                    wr_wrap <= ~wr_wrap;
                end else begin
                    wr_idx <= wr_idx + 1'b1;
                end
            end
        end
    end

endmodule

/* rob/rob.sv */
module rob #(
    parameter int ID_BITS  = 4,
    parameter int PRN_BITS = 6,
    parameter int FU_COUNT = 4
) (
    input  logic                              clk,
    input  logic                              rst,

    // Dispatch handshake and result
    input  logic                              dispatch_valid,
    output logic                              dispatch_ready,
    input  logic [core_cfg_pkg::PC_BITS-1:0]  dispatch_pc,
    input  logic                              dispatch_dest_valid,
    input  logic [core_cfg_pkg::ARN_BITS-1:0] dispatch_dest_arn,
    output logic                              dispatch_done,
    output logic [ID_BITS-1:0]                dispatch_inst_id,
    output logic [PRN_BITS-1:0]               dispatch_new_prn,
    output logic [PRN_BITS-1:0]               dispatch_old_prn,

    // Free list pop side
    output logic                              alloc_req,
    input  logic [PRN_BITS-1:0]               alloc_prn,
    input  logic                              free_empty,

    // Rename map lookup and update
    input  logic [PRN_BITS-1:0]               map_read_prn,
    output logic                              map_write_en,
    output logic [core_cfg_pkg::ARN_BITS-1:0] map_write_arn,
    output logic [PRN_BITS-1:0]               map_write_prn,

    // Completion from the functional units
    input  logic                              complete_valid [FU_COUNT],
    input  logic [ID_BITS-1:0]                complete_inst_id [FU_COUNT],

    // Flush request, target included
    input  logic                              flush_req,
    input  logic [ID_BITS-1:0]                flush_to_id,

    output logic                              restore_en,
    output logic [core_cfg_pkg::ARN_BITS-1:0] restore_arn,
    output logic [PRN_BITS-1:0]               restore_prn,
    output logic                              free_push,
    output logic [PRN_BITS-1:0]               free_prn,

    // One pulse per retired or flushed entry
    output logic                              retire_valid,
    output logic [ID_BITS-1:0]                retire_inst_id,
    output logic                              retire_flush,
    output logic [core_cfg_pkg::PC_BITS-1:0]  retire_pc,
    output logic                              stall_rename
);

    localparam int DEPTH = 1 << ID_BITS;

    rob_types_pkg::rob_state_t   state [DEPTH];
    rob_types_pkg::rob_payload_u payload [DEPTH];
    logic                              ent_dest_valid [DEPTH];
    logic [core_cfg_pkg::ARN_BITS-1:0] ent_dest_arn [DEPTH];
    logic [PRN_BITS-1:0]               ent_new_prn [DEPTH];
    logic [PRN_BITS-1:0]               ent_old_prn [DEPTH];

    // head is the next free slot, tail the oldest live entry
    logic [ID_BITS-1:0] head;
    logic [ID_BITS-1:0] tail;
    logic               full;

    logic               flushing;
    logic [ID_BITS-1:0] walk_ptr;
    logic [ID_BITS-1:0] walk_start;
    logic [ID_BITS-1:0] walk_target;

    logic               need_prn;
    logic               fire;
    logic               retire_fire;
    logic               walk_skip;
    logic               walk_step;
    logic               walk_at_target;
    logic               extend;
    logic [ID_BITS-1:0] skip_to;

    // Age order is measured from the tail, so wrap does not matter
    function automatic logic is_older(input logic [ID_BITS-1:0] a, input logic [ID_BITS-1:0] b,
                                      input logic [ID_BITS-1:0] base);
        logic [ID_BITS-1:0] age_a;
        logic [ID_BITS-1:0] age_b;
        age_a = a - base;
        age_b = b - base;
        return age_a < age_b;
    endfunction

    function automatic rob_types_pkg::rob_payload_u make_link(input logic [ID_BITS-1:0] id);
        rob_types_pkg::rob_payload_u p;
        p.link.zero      = '0;
        p.link.target_id = rob_types_pkg::LINK_BITS'(id);
        return p;
    endfunction

    // Writes to arn 0 are treated as having no destination
    assign need_prn       = dispatch_dest_valid && dispatch_dest_arn != '0;
    assign dispatch_ready = !flush_req && !flushing && !full && (!need_prn || !free_empty);
    assign fire           = dispatch_valid && dispatch_ready;

    assign alloc_req     = fire && need_prn;
    assign map_write_en  = fire && need_prn;
    assign map_write_arn = dispatch_dest_arn;
    assign map_write_prn = alloc_prn;

    assign retire_fire = !flush_req && !flushing && (head != tail || full)
                         && state[tail] == rob_types_pkg::COMPLETE;

    // An already flushed block is jumped over using its link
    assign skip_to        = payload[walk_ptr].link.target_id[ID_BITS-1:0];
    assign walk_skip      = flushing && state[walk_ptr] == rob_types_pkg::FLUSHED;
    assign walk_step      = flushing && !walk_skip;
    assign walk_at_target = walk_skip ? !is_older(walk_target, skip_to, tail)
                                      : walk_ptr == walk_target;
    assign extend         = flush_req && flushing && is_older(flush_to_id, walk_target, tail);

    assign restore_en  = walk_step && ent_dest_valid[walk_ptr];
    assign restore_arn = ent_dest_arn[walk_ptr];
    assign restore_prn = ent_old_prn[walk_ptr];

    // Retire frees the overwritten prn, a flush step frees the new one
    assign free_push = retire_fire ? ent_dest_valid[tail] : restore_en;
    assign free_prn  = retire_fire ? ent_old_prn[tail] : ent_new_prn[walk_ptr];

    assign stall_rename = flush_req || flushing || (retire_valid && retire_flush);

    always_ff @(posedge clk) begin
        if (rst) begin
            head          <= '0;
            tail          <= '0;
            full          <= 1'b0;
            flushing      <= 1'b0;
            walk_ptr      <= '0;
            walk_start    <= '0;
            walk_target   <= '0;
            dispatch_done <= 1'b0;
            retire_valid  <= 1'b0;
            for (int i = 0; i < DEPTH; i++) begin
                state[i] <= rob_types_pkg::ISSUED;
            end
        end else begin
            dispatch_done <= fire;
            retire_valid  <= 1'b0;

            for (int i = 0; i < FU_COUNT; i++) begin
                if (complete_valid[i] && state[complete_inst_id[i]] == rob_types_pkg::ISSUED) begin
                    state[complete_inst_id[i]] <= rob_types_pkg::COMPLETE;
                end
            end

            if (fire) begin
                state[head]          <= rob_types_pkg::ISSUED;
                payload[head].pc     <= dispatch_pc;
                ent_dest_valid[head] <= need_prn;
                ent_dest_arn[head]   <= dispatch_dest_arn;
                ent_new_prn[head]    <= need_prn ? alloc_prn : '0;
                ent_old_prn[head]    <= need_prn ? map_read_prn : '0;
                dispatch_inst_id     <= head;
                dispatch_new_prn     <= need_prn ? alloc_prn : '0;
                dispatch_old_prn     <= need_prn ? map_read_prn : '0;
                head                 <= head + 1'b1;
            end

            if (fire && !retire_fire) begin
                full <= ID_BITS'(head + 1'b1) == tail;
            end else if (retire_fire && !fire) begin
                full <= 1'b0;
            end

            if (retire_fire) begin
                retire_valid   <= 1'b1;
                retire_flush   <= 1'b0;
                retire_inst_id <= tail;
                retire_pc      <= payload[tail].pc;
                tail           <= tail + 1'b1;
            end

            if (flush_req && !flushing) begin
                flushing    <= 1'b1;
                walk_ptr    <= head - 1'b1;
                walk_start  <= head - 1'b1;
                walk_target <= flush_to_id;
            end else if (extend) begin
                // Older request, same walk goes further down
                walk_target         <= flush_to_id;
                payload[walk_start] <= make_link(flush_to_id);
            end

            if (walk_step) begin
                state[walk_ptr] <= rob_types_pkg::FLUSHED;
                retire_valid    <= 1'b1;
                retire_flush    <= 1'b1;
                retire_inst_id  <= walk_ptr;
                retire_pc       <= payload[walk_ptr].pc;
                if (walk_ptr == walk_start) begin
                    // PC goes out with this pulse, the word then holds the link
                    payload[walk_ptr] <= make_link(extend ? flush_to_id : walk_target);
                end
            end

            if (flushing) begin
                if (walk_at_target && !extend) begin
                    flushing <= 1'b0;
                    head     <= walk_target;
                    full     <= 1'b0;
                end else begin
                    walk_ptr <= walk_skip ? skip_to - 1'b1 : walk_ptr - 1'b1;
                end
            end
        end
    end

endmodule

/* design/ooo_backend_top.sv */
module ooo_backend_top #(
    parameter int ID_BITS  = core_cfg_pkg::DEFAULT_ID_BITS,
    parameter int PRN_BITS = core_cfg_pkg::DEFAULT_PRN_BITS,
    parameter int FU_COUNT = core_cfg_pkg::DEFAULT_FU_COUNT
) (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              dispatch_valid,
    output logic                              dispatch_ready,
    input  logic [core_cfg_pkg::PC_BITS-1:0]  dispatch_pc,
    input  logic                              dispatch_dest_valid,
    input  logic [core_cfg_pkg::ARN_BITS-1:0] dispatch_dest_arn,
    output logic                              dispatch_done,
    output logic [ID_BITS-1:0]                dispatch_inst_id,
    output logic [PRN_BITS-1:0]               dispatch_new_prn,
    output logic [PRN_BITS-1:0]               dispatch_old_prn,

    input  logic                              complete_valid [FU_COUNT],
    input  logic [ID_BITS-1:0]                complete_inst_id [FU_COUNT],

    input  logic                              flush_req,
    input  logic [ID_BITS-1:0]                flush_to_id,

    output logic                              retire_valid,
    output logic [ID_BITS-1:0]                retire_inst_id,
    output logic                              retire_flush,
    output logic [core_cfg_pkg::PC_BITS-1:0]  retire_pc,
    output logic                              stall_rename
);

    logic                              alloc_req;
    logic [PRN_BITS-1:0]               alloc_prn;
    logic                              free_empty;
    logic                              free_push;
    logic [PRN_BITS-1:0]               free_prn;
    logic [PRN_BITS-1:0]               map_read_prn;
    logic                              map_write_en;
    logic [core_cfg_pkg::ARN_BITS-1:0] map_write_arn;
    logic [PRN_BITS-1:0]               map_write_prn;
    logic                              restore_en;
    logic [core_cfg_pkg::ARN_BITS-1:0] restore_arn;
    logic [PRN_BITS-1:0]               restore_prn;

    rename_map #(
        .PRN_BITS(PRN_BITS)
    ) u_rename_map (
        .clk        (clk),
        .rst        (rst),
        .read_arn   (dispatch_dest_arn),
        .read_prn   (map_read_prn),
        .write_en   (map_write_en),
        .write_arn  (map_write_arn),
        .write_prn  (map_write_prn),
        .restore_en (restore_en),
        .restore_arn(restore_arn),
        .restore_prn(restore_prn)
    );

    free_list #(
        .PRN_BITS (PRN_BITS),
        .ARCH_REGS(core_cfg_pkg::ARCH_REGS)
    ) u_free_list (
        .clk      (clk),
        .rst      (rst),
        .alloc_req(alloc_req),
        .alloc_prn(alloc_prn),
        .empty    (free_empty),
        .free_push(free_push),
        .free_prn (free_prn)
    );

    rob #(
        .ID_BITS (ID_BITS),
        .PRN_BITS(PRN_BITS),
        .FU_COUNT(FU_COUNT)
    ) u_rob (
        .clk                (clk),
        .rst                (rst),
        .dispatch_valid     (dispatch_valid),
        .dispatch_ready     (dispatch_ready),
        .dispatch_pc        (dispatch_pc),
        .dispatch_dest_valid(dispatch_dest_valid),
        .dispatch_dest_arn  (dispatch_dest_arn),
        .dispatch_done      (dispatch_done),
        .dispatch_inst_id   (dispatch_inst_id),
        .dispatch_new_prn   (dispatch_new_prn),
        .dispatch_old_prn   (dispatch_old_prn),
        .alloc_req          (alloc_req),
        .alloc_prn          (alloc_prn),
        .free_empty         (free_empty),
        .map_read_prn       (map_read_prn),
        .map_write_en       (map_write_en),
        .map_write_arn      (map_write_arn),
        .map_write_prn      (map_write_prn),
        .complete_valid     (complete_valid),
        .complete_inst_id   (complete_inst_id),
        .flush_req          (flush_req),
        .flush_to_id        (flush_to_id),
        .restore_en         (restore_en),
        .restore_arn        (restore_arn),
        .restore_prn        (restore_prn),
        .free_push          (free_push),
        .free_prn           (free_prn),
        .retire_valid       (retire_valid),
        .retire_inst_id     (retire_inst_id),
        .retire_flush       (retire_flush),
        .retire_pc          (retire_pc),
        .stall_rename       (stall_rename)
    );

endmodule

/* bench/tb_ooo_backend.sv */
module tb_ooo_backend;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ID_BITS        = 4;
    localparam int PRN_BITS       = 6;
    localparam int FU_COUNT       = 4;
    localparam int TOTAL_DISPATCH = 84;
    localparam int TIMEOUT_LIMIT  = 20 * TOTAL_DISPATCH + 200;

    localparam int OP_DISPATCH = 0;
    localparam int OP_COMPLETE = 1;
    localparam int OP_FLUSH    = 2;

    logic                clk = 1'b0;
    logic                rst;
    logic                dispatch_valid;
    logic                dispatch_ready;
    logic [63:0]         dispatch_pc;
    logic                dispatch_dest_valid;
    logic [4:0]          dispatch_dest_arn;
    logic                dispatch_done;
    logic [ID_BITS-1:0]  dispatch_inst_id;
    logic [PRN_BITS-1:0] dispatch_new_prn;
    logic [PRN_BITS-1:0] dispatch_old_prn;
    logic                complete_valid [FU_COUNT];
    logic [ID_BITS-1:0]  complete_inst_id [FU_COUNT];
    logic                flush_req;
    logic [ID_BITS-1:0]  flush_to_id;
    logic                retire_valid;
    logic [ID_BITS-1:0]  retire_inst_id;
    logic                retire_flush;
    logic [63:0]         retire_pc;
    logic                stall_rename;

    // Reference model state
    logic [PRN_BITS-1:0] m_map [32];
    logic [PRN_BITS-1:0] m_free [$];
    logic [63:0]         m_pc [16];
    logic                m_dv [16];
    logic [4:0]          m_arn [16];
    logic [PRN_BITS-1:0] m_new [16];
    logic [PRN_BITS-1:0] m_old [16];
    logic                m_done [16];
    logic [3:0]          m_head;
    logic [3:0]          m_tail;
    int                  m_count;

    // Predictions, {id, new, old} and {id, flush, pc}
    logic [15:0] exp_disp [$];
    logic [68:0] exp_ret [$];

    logic [31:0] lcg_state;
    int          cycles;
    logic [63:0] next_pc;

    ooo_backend_top #(
        .ID_BITS (ID_BITS),
        .PRN_BITS(PRN_BITS),
        .FU_COUNT(FU_COUNT)
    ) UUT (
        .clk                (clk),
        .rst                (rst),
        .dispatch_valid     (dispatch_valid),
        .dispatch_ready     (dispatch_ready),
        .dispatch_pc        (dispatch_pc),
        .dispatch_dest_valid(dispatch_dest_valid),
        .dispatch_dest_arn  (dispatch_dest_arn),
        .dispatch_done      (dispatch_done),
        .dispatch_inst_id   (dispatch_inst_id),
        .dispatch_new_prn   (dispatch_new_prn),
        .dispatch_old_prn   (dispatch_old_prn),
        .complete_valid     (complete_valid),
        .complete_inst_id   (complete_inst_id),
        .flush_req          (flush_req),
        .flush_to_id        (flush_to_id),
        .retire_valid       (retire_valid),
        .retire_inst_id     (retire_inst_id),
        .retire_flush       (retire_flush),
        .retire_pc          (retire_pc),
        .stall_rename       (stall_rename)
    );

    always #4 clk = ~clk;

    task automatic fail_with(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    function automatic int unsigned rand_below(input int unsigned n);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) % n;
    endfunction

    function automatic void model_step(input int op, input logic [3:0] id,
                                       input logic [63:0] pc, input logic dv,
                                       input logic [4:0] arn);
        logic                need;
        logic [PRN_BITS-1:0] np;
        logic [PRN_BITS-1:0] opr;
        logic [3:0]          k;
        need = dv && arn != 5'd0;
        np   = '0;
        opr  = '0;
        k    = m_head;
        if (op == OP_DISPATCH) begin
            if (need) begin
                np         = m_free.pop_front();
                opr        = m_map[arn];
                m_map[arn] = np;
            end
            m_pc[m_head]   = pc;
            m_dv[m_head]   = need;
            m_arn[m_head]  = arn;
            m_new[m_head]  = np;
            m_old[m_head]  = opr;
            m_done[m_head] = 1'b0;
            exp_disp.push_back({m_head, np, opr});
            m_head  = m_head + 4'd1;
            m_count = m_count + 1;
        end else if (op == OP_COMPLETE) begin
            m_done[id] = 1'b1;
            // Oldest completed entries leave in program order
            while (m_count > 0 && m_done[m_tail]) begin
                exp_ret.push_back({m_tail, 1'b0, m_pc[m_tail]});
                if (m_dv[m_tail]) begin
                    m_free.push_back(m_old[m_tail]);
                end
                m_done[m_tail] = 1'b0;
                m_tail  = m_tail + 4'd1;
                m_count = m_count - 1;
            end
        end else begin
            // Youngest first down to the target
            do begin
                k = k - 4'd1;
                exp_ret.push_back({k, 1'b1, m_pc[k]});
                if (m_dv[k]) begin
                    m_map[m_arn[k]] = m_old[k];
                    m_free.push_back(m_new[k]);
                end
                m_done[k] = 1'b0;
                m_count   = m_count - 1;
            end while (k != id);
            m_head = id;
        end
    endfunction

    task automatic dispatch_one(input logic [63:0] pc, input logic dv, input logic [4:0] arn);
        logic ok;
        dispatch_valid      = 1'b1;
        dispatch_pc         = pc;
        dispatch_dest_valid = dv;
        dispatch_dest_arn   = arn;
        ok = 1'b0;
        while (!ok) begin
            @(negedge clk);
            ok = dispatch_ready;
            @(posedge clk);
            #1;
        end
        model_step(OP_DISPATCH, '0, pc, dv, arn);
        dispatch_valid = 1'b0;
    endtask

    task automatic dispatch_random(input int n);
        for (int i = 0; i < n; i++) begin
            dispatch_one(next_pc, rand_below(4) != 0, 5'(rand_below(32)));
            next_pc = next_pc + 64'd4;
        end
    endtask

    // Up to n live entries complete in random order, two per cycle
    task automatic complete_random(input int n);
        logic [3:0] pend [$];
        logic [3:0] k;
        int         idx;
        int         left;
        pend = {};
        for (int i = 0; i < m_count; i++) begin
            k = m_tail + 4'(i);
            if (!m_done[k]) begin
                pend.push_back(k);
            end
        end
        left = n;
        while (left > 0 && pend.size() > 0) begin
            for (int p = 0; p < 2; p++) begin
                if (left > 0 && pend.size() > 0) begin
                    idx = int'(rand_below(pend.size()));
                    k   = pend[idx];
                    pend.delete(idx);
                    complete_valid[p * 2]   = 1'b1;
                    complete_inst_id[p * 2] = k;
                    model_step(OP_COMPLETE, k, '0, 1'b0, '0);
                    left = left - 1;
                end
            end
            @(posedge clk);
            #1;
            for (int p = 0; p < FU_COUNT; p++) begin
                complete_valid[p] = 1'b0;
            end
        end
    endtask

    // Oldest live entry completes alone, so one retire follows
    task automatic complete_oldest();
        complete_valid[0]   = 1'b1;
        complete_inst_id[0] = m_tail;
        model_step(OP_COMPLETE, m_tail, '0, 1'b0, '0);
        @(posedge clk);
        #1;
        complete_valid[0] = 1'b0;
    endtask

    task automatic flush_to(input logic [3:0] t1, input logic use2, input logic [3:0] t2);
        model_step(OP_FLUSH, use2 ? t2 : t1, '0, 1'b0, '0);
        flush_req   = 1'b1;
        flush_to_id = t1;
        @(negedge clk);
        assert (stall_rename)
        else fail_with("stall_rename stayed low in the cycle of a flush request");
        @(posedge clk);
        #1;
        if (use2) begin
            // Older target while the first walk runs
            flush_to_id = t2;
            @(posedge clk);
            #1;
        end
        flush_req = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_disp.size() != 0 || exp_ret.size() != 0 || stall_rename) begin
            @(posedge clk);
            #1;
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT_LIMIT) begin
            fail_with("Timeout: the test did not finish within the cycle limit");
        end
    end

    // Compare outputs in the middle of the cycle
    always @(negedge clk) begin
        logic [15:0] d;
        logic [68:0] r;
        if (!rst && dispatch_done) begin
            assert (exp_disp.size() > 0)
            else fail_with("dispatch_done pulsed with no dispatch expected");
            d = exp_disp.pop_front();
            assert (dispatch_inst_id == d[15:12])
            else fail_with($sformatf("Mismatch dispatch_inst_id: got %h expected %h",
                                     dispatch_inst_id, d[15:12]));
            assert (dispatch_new_prn == d[11:6])
            else fail_with($sformatf("Mismatch dispatch_new_prn: got %h expected %h",
                                     dispatch_new_prn, d[11:6]));
            assert (dispatch_old_prn == d[5:0])
            else fail_with($sformatf("Mismatch dispatch_old_prn: got %h expected %h",
                                     dispatch_old_prn, d[5:0]));
        end
        if (!rst && retire_valid) begin
            assert (exp_ret.size() > 0)
            else fail_with("retire_valid pulsed with no retire or flush expected");
            r = exp_ret.pop_front();
            assert (retire_inst_id == r[68:65])
            else fail_with($sformatf("Mismatch retire_inst_id: got %h expected %h",
                                     retire_inst_id, r[68:65]));
            assert (retire_flush == r[64])
            else fail_with($sformatf("Mismatch retire_flush: got %h expected %h",
                                     retire_flush, r[64]));
            assert (retire_pc == r[63:0])
            else fail_with($sformatf("Mismatch retire_pc: got %h expected %h",
                                     retire_pc, r[63:0]));
            if (retire_flush) begin
                assert (stall_rename)
                else fail_with("stall_rename was low during a flush pulse");
            end
        end
    end

    initial begin
        rst                 = 1'b1;
        dispatch_valid      = 1'b0;
        dispatch_pc         = '0;
        dispatch_dest_valid = 1'b0;
        dispatch_dest_arn   = '0;
        flush_req           = 1'b0;
        flush_to_id         = '0;
        for (int p = 0; p < FU_COUNT; p++) begin
            complete_valid[p]   = 1'b0;
            complete_inst_id[p] = '0;
        end
        lcg_state = 32'd7783;
        cycles    = 0;
        next_pc   = 64'h1000;
        m_head    = '0;
        m_tail    = '0;
        m_count   = 0;
        for (int i = 0; i < 32; i++) begin
            m_map[i]  = 6'(i);
            m_free.push_back(6'(32 + i));
        end
        repeat (10) @(posedge clk);
        #1;
        assert (!retire_valid && !dispatch_done && !stall_rename)
        else fail_with("An output pulse was high while reset was applied");
        rst = 1'b0;

        // Fresh prns, random completion order, wrap of ids
        dispatch_random(12);
        complete_random(100);
        wait_idle();
        for (int round = 0; round < 3; round++) begin
            dispatch_random(10);
            complete_random(100);
            wait_idle();
        end

        // Single flush to a random live entry
        dispatch_random(8);
        complete_random(2);
        wait_idle();
        flush_to(m_tail + 4'(rand_below(m_count)), 1'b0, '0);
        wait_idle();
        dispatch_random(4);
        complete_random(100);
        wait_idle();

        // ROB full holds dispatch back until a retire
        dispatch_random(16);
        dispatch_valid      = 1'b1;
        dispatch_dest_valid = 1'b0;
        repeat (3) begin
            @(negedge clk);
            assert (!dispatch_ready)
            else fail_with("dispatch_ready went high while the ROB was full");
        end
        @(posedge clk);
        #1;
        dispatch_valid = 1'b0;
        complete_oldest();
        dispatch_random(1);
        complete_random(100);
        wait_idle();

        // Second flush request to an older id extends the walk
        dispatch_random(10);
        wait_idle();
        flush_to(m_tail + 4'd6, 1'b1, m_tail + 4'd1);
        wait_idle();
        dispatch_random(3);
        complete_random(100);
        wait_idle();

        repeat (4) @(posedge clk);
        if (exp_disp.size() == 0 && exp_ret.size() == 0 && m_count == 0 && !stall_rename) begin
            $display(">>> PASS");
            $finish;
        end else begin
            fail_with("Predictions left over at the end of the test");
        end
    end

endmodule

/* sources.f */
common/core_cfg_pkg.sv
common/rob_types_pkg.sv
rename/rename_map.sv
rename/free_list.sv
rob/rob.sv
design/ooo_backend_top.sv
bench/tb_ooo_backend.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ooo_backend -f sources.f

out=$(./obj_dir/Vtb_ooo_backend 2>&1) || true
printf '%s\n' "$out"

# Exit status follows the search for the pass line
printf '%s\n' "$out" | grep -qx '>>> PASS'
